/* Makefile */
VERILATOR ?= verilator
FILELIST ?= files.f
TB_TOP ?= tb_loop_unroll
RTL_TOP ?= loop_unroll_unit
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing
PASS_TEXT ?= Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_loop_unroll.sv */
`timescale 1ns/1ps

module tb_loop_unroll import isa_pkg::*, lat_pkg::*; ();

	localparam int N_BUNDLES = 3000;
	localparam int RST_CYCLES = 4;
	localparam int CLK_PERIOD = 20;
	localparam int WATCHDOG_NS = (N_BUNDLES + RST_CYCLES) * CLK_PERIOD * 2;
	localparam logic [31:0] SEED = 32'h863b2d41;

	logic clk = 1'b0;
	logic rst;
	logic bundle_valid;
	logic [SLOT_W-1:0] fetch_pc;
	logic [SLOTS*SLOT_W-1:0] bundle_insts;
	logic mis_pred;
	logic [ST_W-1:0] loop_state;
	logic loop_start;
	logic finish_unroll;
	logic stall_fetch;
	logic [SLOTS-1:0] inst_valid;

	// reference model, decode stage
	logic m_dv;
	logic [SLOT_W-1:0] m_dpc;
	logic m_hit;
	int m_slot;
	logic [SLOT_W-1:0] m_tgt;

	// reference model, loop table and fsm
	logic m_ev [LAT_ENTRIES];
	logic [SLOT_W-1:0] m_es [LAT_ENTRIES];
	logic [SLOT_W-1:0] m_ef [LAT_ENTRIES];
	int m_em [LAT_ENTRIES];
	logic [PTR_W-1:0] m_ptr;
	logic [ST_W-1:0] m_state;
	logic [SLOT_W-1:0] m_tstart;
	logic [SLOT_W-1:0] m_tfall;
	logic [SLOT_W-1:0] m_dfall;
	int m_drem;
	int m_cnt;

	// expected outputs after the current edge
	logic [ST_W-1:0] e_state;
	logic [SLOTS-1:0] e_mask;
	logic e_start;
	logic e_finish;
	logic e_stall;

	// program walker
	logic [SLOT_W-1:0] g_pc;
	logic [SLOT_W-1:0] g_start;
	int g_len;
	int g_iters;
	logic g_in_loop;
	logic [SLOT_W-1:0] hist_start [8];
	int hist_len [8];
	logic [2:0] hist_wr;
	int hist_n;

	int n_checks;
	int n_errors;
	int n_starts;
	int n_finishes;
	int n_stalls;

	always #(CLK_PERIOD / 2) clk = ~clk;

	loop_unroll_unit loop_unroll_unit_i (
		.clk           (clk),
		.rst           (rst),
		.bundle_valid  (bundle_valid),
		.fetch_pc      (fetch_pc),
		.bundle_insts  (bundle_insts),
		.mis_pred      (mis_pred),
		.loop_state    (loop_state),
		.loop_start    (loop_start),
		.finish_unroll (finish_unroll),
		.stall_fetch   (stall_fetch),
		.inst_valid    (inst_valid)
	);

	function automatic logic [SLOT_W-1:0] alu_word();
		insn_word_u w;
		w.alu.opcode = (($urandom % 2) == 0) ? OP_ADD : OP_SUB;
		w.alu.rd = REG_W'($urandom);
		w.alu.rs = REG_W'($urandom);
		w.alu.imm = REG_W'($urandom);
		return w;
	endfunction

	// walks the synthetic program, one bundle per call
	task automatic next_bundle(output logic v, output logic [SLOT_W-1:0] pc,
			output logic [SLOTS*SLOT_W-1:0] insts);
		insn_word_u br;
		logic [SLOT_W-1:0] end_pc;
		logic [SLOT_W-1:0] off;
		logic closes;
		logic [2:0] k;
		closes = 1'b0;
		off = '0;
		if (($urandom % 8) == 0) begin
			v = 1'b0;
			pc = SLOT_W'($urandom);
			insts = {$urandom, $urandom};
		end else begin
			if (!g_in_loop && ($urandom % 4) == 0) begin
				if (hist_n > 0 && ($urandom % 3) == 0) begin
					// revisit an older loop
					k = 3'($urandom % hist_n);
					g_start = hist_start[k];
					g_len = hist_len[k];
					g_pc = g_start;
				end else begin
					g_start = g_pc;
					g_len = 1 + int'($urandom % 80);
					hist_start[hist_wr] = g_start;
					hist_len[hist_wr] = g_len;
					hist_wr = hist_wr + 3'd1;
					if (hist_n < 8)
						hist_n++;
				end
				g_iters = 1 + int'($urandom % 12);
				g_in_loop = 1'b1;
			end
			if (g_in_loop) begin
				end_pc = g_start + SLOT_W'(g_len - 1);
				off = end_pc - g_pc;
				closes = off < SLOT_W'(SLOTS);
			end
			br.br.opcode = OP_BRANCH;
			br.br.cond = 1'($urandom);
			br.br.offset = OFF_W'(g_start - end_pc);
			v = 1'b1;
			pc = g_pc;
			for (int i = 0; i < SLOTS; i++)
				insts[i*SLOT_W +: SLOT_W] = (closes && SLOT_W'(i) == off) ? br : alu_word();
			if (closes) begin
				g_iters--;
				if (g_iters == 0)
					g_in_loop = 1'b0;
			end
			g_pc = (closes && g_in_loop) ? g_start : g_pc + SLOT_W'(4);
		end
	endtask

	task automatic reset_model();
		for (int i = 0; i < LAT_ENTRIES; i++)
			m_ev[i] = 1'b0;
		m_ptr = '0;
		m_state = ST_IDLE;
		m_dv = 1'b0;
		m_cnt = 0;
		e_state = ST_IDLE;
		e_mask = '0;
		e_start = 1'b0;
		e_finish = 1'b0;
		e_stall = 1'b0;
	endtask

	// first backward branch of the bundle on the decode inputs
	task automatic capture_bundle();
		insn_word_u w;
		logic [SLOT_W-1:0] off;
		m_dv = bundle_valid;
		m_dpc = fetch_pc;
		m_hit = 1'b0;
		m_slot = 0;
		m_tgt = '0;
		for (int i = 0; i < SLOTS; i++) begin
			w = bundle_insts[i*SLOT_W +: SLOT_W];
			if (!m_hit && w.br.opcode == OP_BRANCH && w.br.offset[OFF_W-1]) begin
				off = {{(SLOT_W-OFF_W){w.br.offset[OFF_W-1]}}, w.br.offset};
				m_hit = 1'b1;
				m_slot = i;
				m_tgt = fetch_pc + SLOT_W'(i) + off;
			end
		end
	endtask

	task automatic execute_step();
		logic abort;
		logic hit;
		logic known;
		logic xs;
		logic disp;
		logic close;
		logic twrite;
		logic tload;
		logic end_hit;
		logic fin;
		logic [PTR_W-1:0] idx;
		logic [SLOT_W-1:0] br_addr;
		logic [SLOT_W-1:0] blen;
		logic [SLOT_W-1:0] tlen;
		logic [SLOT_W-1:0] fall;
		logic [SLOT_W-1:0] end_off;
		int rem;
		hit = 1'b0;
		known = 1'b0;
		idx = '0;
		for (int i = 0; i < LAT_ENTRIES; i++) begin
			if (m_ev[i] && m_es[i] == m_dpc && !hit) begin
				hit = 1'b1;
				idx = PTR_W'(i);
			end
			if (m_ev[i] && m_es[i] == m_tgt)
				known = 1'b1;
		end
		abort = mis_pred && m_state != ST_IDLE;
		xs = m_dv && hit && m_state != ST_DISPATCH && !abort;
		disp = xs || (m_state == ST_DISPATCH && !abort);
		br_addr = m_dpc + SLOT_W'(m_slot);
		blen = br_addr + SLOT_W'(1) - m_tgt;
		close = m_state == ST_TRAIN && m_dv && m_hit && br_addr == m_tfall - SLOT_W'(1);
		twrite = close && !abort && !xs;
		tload = m_dv && m_hit && !known && blen != '0 && blen <= SLOT_W'(BUF_DEPTH) &&
			!abort && !xs && (m_state == ST_IDLE || (m_state == ST_TRAIN && !close));
		// loop end counting
		fall = xs ? m_ef[idx] : m_dfall;
		rem = xs ? m_em[idx] : m_drem;
		end_off = fall - SLOT_W'(1) - m_dpc;
		end_hit = disp && m_dv && end_off < SLOT_W'(SLOTS);
		if (end_hit)
			rem = rem - 1;
		fin = end_hit && rem == 0;
		for (int i = 0; i < SLOTS; i++)
			e_mask[i] = m_dv && (!end_hit || SLOT_W'(i) <= end_off);
		e_start = xs;
		e_finish = fin;
		if (!disp || fin) begin
			m_cnt = 0;
			e_stall = 1'b0;
		end else begin
			m_cnt = (xs ? 0 : m_cnt) + $countones(e_mask);
			e_stall = m_cnt >= BUF_DEPTH;
		end
		if (twrite) begin
			tlen = m_tfall - m_tstart;
			m_ev[m_ptr] = 1'b1;
			m_es[m_ptr] = m_tstart;
			m_ef[m_ptr] = m_tfall;
			m_em[m_ptr] = BUF_DEPTH / int'(tlen);
			m_ptr = m_ptr + PTR_W'(1);
		end
		if (tload) begin
			m_tstart = m_tgt;
			m_tfall = br_addr + SLOT_W'(1);
		end
		if (xs)
			m_dfall = fall;
		if (disp)
			m_drem = rem;
		case (m_state)
			ST_IDLE: m_state = xs ? ST_DISPATCH : (tload ? ST_TRAIN : ST_IDLE);
			ST_TRAIN: begin
				if (abort || twrite)
					m_state = ST_IDLE;
				else if (xs)
					m_state = ST_DISPATCH;
			end
			default: begin
				if (abort || fin)
					m_state = ST_IDLE;
			end
		endcase
		e_state = m_state;
	endtask

	task automatic check_outputs();
		n_checks++;
		if (loop_state !== e_state) begin
			n_errors++;
			$display("MISMATCH loop_state expected %h got %h at %0t", e_state, loop_state, $time);
		end
		if (inst_valid !== e_mask) begin
			n_errors++;
			$display("MISMATCH inst_valid expected %h got %h at %0t", e_mask, inst_valid, $time);
		end
		if (loop_start !== e_start) begin
			n_errors++;
			$display("MISMATCH loop_start expected %h got %h at %0t", e_start, loop_start, $time);
		end
		if (finish_unroll !== e_finish) begin
			n_errors++;
			$display("MISMATCH finish_unroll expected %h got %h at %0t", e_finish, finish_unroll,
				$time);
		end
		if (stall_fetch !== e_stall) begin
			n_errors++;
			$display("MISMATCH stall_fetch expected %h got %h at %0t", e_stall, stall_fetch, $time);
		end
		if (e_start)
			n_starts++;
		if (e_finish)
			n_finishes++;
		if (e_stall)
			n_stalls++;
	endtask

	initial begin
		logic v;
		logic [SLOT_W-1:0] pc;
		logic [SLOTS*SLOT_W-1:0] insts;
		void'($urandom(SEED));
		rst <= 1'b1;
		bundle_valid <= 1'b0;
		fetch_pc <= '0;
		bundle_insts <= '0;
		mis_pred <= 1'b0;
		g_pc = 16'h0100;
		g_start = '0;
		g_len = 0;
		g_iters = 0;
		g_in_loop = 1'b0;
		hist_wr = '0;
		hist_n = 0;
		n_checks = 0;
		n_errors = 0;
		n_starts = 0;
		n_finishes = 0;
		n_stalls = 0;
		reset_model();
		for (int cyc = 0; cyc < RST_CYCLES + N_BUNDLES; cyc++) begin
			@(posedge clk);
			// model sees the same edge as the dut
			if (rst) begin
				reset_model();
			end else begin
				execute_step();
				capture_bundle();
			end
			if (cyc >= RST_CYCLES - 1) begin
				next_bundle(v, pc, insts);
				rst <= 1'b0;
				bundle_valid <= v;
				fetch_pc <= pc;
				bundle_insts <= insts;
				mis_pred <= ($urandom % 64) == 0;
			end
			@(negedge clk);
			check_outputs();
		end
		if (n_starts == 0 || n_finishes == 0) begin
			n_errors++;
			$display("no loop was dispatched to completion during the run");
		end
		$display("checks %0d errors %0d starts %0d finishes %0d stall cycles %0d",
			n_checks, n_errors, n_starts, n_finishes, n_stalls);
		if (n_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the bundle sequence completed");
		$display("Test FAILED");
		$finish;
	end

endmodule

/* common/isa_pkg.sv */
package isa_pkg;

	// fetch geometry
	localparam int SLOT_W = 16;
	localparam int SLOTS = 4;
	localparam int SLOT_IDX_W = $clog2(SLOTS);

	// instruction fields
	localparam int OP_W = 4;
	localparam int OFF_W = 11;
	localparam int REG_W = 4;

	localparam logic [OP_W-1:0] OP_ADD = 4'h1;
	localparam logic [OP_W-1:0] OP_SUB = 4'h2;
	localparam logic [OP_W-1:0] OP_BRANCH = 4'hc;

	// one 16-bit word, read as a branch or as an alu op
	typedef union packed {
		struct packed {
			logic [OP_W-1:0] opcode;
			logic cond;
			// two's complement, relative to the branch address
			logic [OFF_W-1:0] offset;
		} br;
		struct packed {
			logic [OP_W-1:0] opcode;
			logic [REG_W-1:0] rd;
			logic [REG_W-1:0] rs;
			logic [REG_W-1:0] imm;
		} alu;
	} insn_word_u;

endpackage

/* common/lat_pkg.sv */
package lat_pkg;

	// loop address table
	localparam int LAT_ENTRIES = 4;
	localparam int PTR_W = $clog2(LAT_ENTRIES);

	// longest trainable body, also the unroll dividend and stall threshold
	localparam int BUF_DEPTH = 64;
	localparam int CNT_W = 7;

	// execute fsm
	localparam int ST_W = 2;
	localparam logic [ST_W-1:0] ST_IDLE = 2'd0;
	localparam logic [ST_W-1:0] ST_TRAIN = 2'd1;
	localparam logic [ST_W-1:0] ST_DISPATCH = 2'd2;

endpackage

/* files.f */
common/isa_pkg.sv
common/lat_pkg.sv
loop_table/lat_decode.sv
loop_table/lat_execute.sv
loop_table/lat_result.sv
hdl/loop_unroll_unit.sv
bench/tb_loop_unroll.sv

/* hdl/loop_unroll_unit.sv */
`timescale 1ns/1ps

module loop_unroll_unit import isa_pkg::*, lat_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    bundle_valid,
	input  logic [SLOT_W-1:0]       fetch_pc,
	input  logic [SLOTS*SLOT_W-1:0] bundle_insts,
	input  logic                    mis_pred,
	output logic [ST_W-1:0]         loop_state,
	output logic                    loop_start,
	output logic                    finish_unroll,
	output logic                    stall_fetch,
	output logic [SLOTS-1:0]        inst_valid
);

	// decode to execute
	logic                  d_valid;
	logic [SLOT_W-1:0]     d_pc;
	logic                  d_bb_hit;
	logic [SLOT_IDX_W-1:0] d_bb_slot;
	logic [SLOT_W-1:0]     d_bb_target;

	// execute to result
	logic                  x_valid;
	logic                  x_start;
	logic                  x_dispatching;
	logic                  x_end_hit;
	logic [SLOT_IDX_W-1:0] x_end_slot;
	logic                  x_finish;

	lat_decode lat_decode_i (
		.clk          (clk),
		.rst          (rst),
		.bundle_valid (bundle_valid),
		.fetch_pc     (fetch_pc),
		.bundle_insts (bundle_insts),
		.d_valid      (d_valid),
		.d_pc         (d_pc),
		.d_bb_hit     (d_bb_hit),
		.d_bb_slot    (d_bb_slot),
		.d_bb_target  (d_bb_target)
	);

	lat_execute lat_execute_i (
		.clk           (clk),
		.rst           (rst),
		.mis_pred      (mis_pred),
		.d_valid       (d_valid),
		.d_pc          (d_pc),
		.d_bb_hit      (d_bb_hit),
		.d_bb_slot     (d_bb_slot),
		.d_bb_target   (d_bb_target),
		.loop_state    (loop_state),
		.x_valid       (x_valid),
		.x_start       (x_start),
		.x_dispatching (x_dispatching),
		.x_end_hit     (x_end_hit),
		.x_end_slot    (x_end_slot),
		.x_finish      (x_finish)
	);

	lat_result lat_result_i (
		.clk           (clk),
		.rst           (rst),
		.x_valid       (x_valid),
		.x_start       (x_start),
		.x_dispatching (x_dispatching),
		.x_end_hit     (x_end_hit),
		.x_end_slot    (x_end_slot),
		.x_finish      (x_finish),
		.inst_valid    (inst_valid),
		.loop_start    (loop_start),
		.finish_unroll (finish_unroll),
		.stall_fetch   (stall_fetch)
	);

endmodule

/* loop_table/lat_decode.sv */
`timescale 1ns/1ps

module lat_decode import isa_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  bundle_valid,
	input  logic [SLOT_W-1:0]     fetch_pc,
	input  logic [SLOTS*SLOT_W-1:0] bundle_insts,
	output logic                  d_valid,
	output logic [SLOT_W-1:0]     d_pc,
	output logic                  d_bb_hit,
	output logic [SLOT_IDX_W-1:0] d_bb_slot,
	output logic [SLOT_W-1:0]     d_bb_target
);

	logic                  bb_hit;
	logic [SLOT_IDX_W-1:0] bb_slot;
	logic [SLOT_W-1:0]     bb_target;

	// scan from the top so the lowest slot wins
	always_comb begin
		insn_word_u w;
		logic [SLOT_W-1:0] slot_addr;
		logic [SLOT_W-1:0] off_ext;
		bb_hit = 1'b0;
		bb_slot = '0;
		bb_target = '0;
		for (int i = SLOTS - 1; i >= 0; i--) begin
			w = bundle_insts[i*SLOT_W +: SLOT_W];
			slot_addr = fetch_pc + SLOT_W'(i);
			off_ext = {{(SLOT_W-OFF_W){w.br.offset[OFF_W-1]}}, w.br.offset};
			// negative offset means backward
			if (w.br.opcode == OP_BRANCH && w.br.offset[OFF_W-1]) begin
				bb_hit = 1'b1;
				bb_slot = SLOT_IDX_W'(i);
				bb_target = slot_addr + off_ext;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			d_valid <= 1'b0;
		end else begin
			d_valid <= bundle_valid;
		end
	end

	always_ff @(posedge clk) begin
		d_pc <= fetch_pc;
		d_bb_hit <= bb_hit;
		d_bb_slot <= bb_slot;
		d_bb_target <= bb_target;
	end

endmodule

/* loop_table/lat_execute.sv */
`timescale 1ns/1ps

module lat_execute import isa_pkg::*, lat_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  mis_pred,
	input  logic                  d_valid,
	input  logic [SLOT_W-1:0]     d_pc,
	input  logic                  d_bb_hit,
	input  logic [SLOT_IDX_W-1:0] d_bb_slot,
	input  logic [SLOT_W-1:0]     d_bb_target,
	output logic [ST_W-1:0]       loop_state,
	output logic                  x_valid,
	output logic                  x_start,
	output logic                  x_dispatching,
	output logic                  x_end_hit,
	output logic [SLOT_IDX_W-1:0] x_end_slot,
	output logic                  x_finish
);

	logic [ST_W-1:0] state;

	// loop address table
	logic [LAT_ENTRIES-1:0] ent_valid;
	logic [SLOT_W-1:0]      ent_start [LAT_ENTRIES];
	logic [SLOT_W-1:0]      ent_fall [LAT_ENTRIES];
	logic [CNT_W-1:0]       ent_len [LAT_ENTRIES];
	logic [CNT_W-1:0]       ent_max [LAT_ENTRIES];
	logic [PTR_W-1:0]       wr_ptr;

	logic [SLOT_W-1:0] train_start;
	logic [SLOT_W-1:0] train_fall;
	logic [SLOT_W-1:0] disp_fall;
	logic [CNT_W-1:0]  disp_rem;

	logic              tbl_hit;
	logic              tgt_known;
	logic [PTR_W-1:0]  hit_idx;
	logic [SLOT_W-1:0] br_addr;
	logic [SLOT_W-1:0] br_len;
	logic              br_ok;
	logic              abort;
	logic              disp_now;
	logic              train_close;
	logic              train_load;
	logic              train_write;
	logic [CNT_W-1:0]  train_len;
	logic [CNT_W-1:0]  max_unroll;
	logic [SLOT_W-1:0] end_addr;
	logic [SLOT_W-1:0] end_off;
	logic [CNT_W-1:0]  rem_cur;
	logic [CNT_W-1:0]  rem_next;

	always_comb begin
		tbl_hit = 1'b0;
		tgt_known = 1'b0;
		hit_idx = '0;
		for (int i = 0; i < LAT_ENTRIES; i++) begin
			if (ent_valid[i] && ent_start[i] == d_pc) begin
				tbl_hit = 1'b1;
				hit_idx = i[PTR_W-1:0];
			end
			if (ent_valid[i] && ent_start[i] == d_bb_target) begin
				tgt_known = 1'b1;
			end
		end
	end

	// candidate loop from the decoded backward branch
	assign br_addr = d_pc + SLOT_W'(d_bb_slot);
	assign br_len = br_addr + SLOT_W'(1) - d_bb_target;
	assign br_ok = d_valid && d_bb_hit && !tgt_known && br_len != '0 &&
		br_len <= SLOT_W'(BUF_DEPTH);

	assign abort = mis_pred && state != ST_IDLE;
	assign x_start = d_valid && tbl_hit && state != ST_DISPATCH && !abort;
	assign disp_now = x_start || (state == ST_DISPATCH && !abort);

	assign train_close = state == ST_TRAIN && d_valid && d_bb_hit &&
		br_addr == train_fall - SLOT_W'(1);
	assign train_write = train_close && !abort && !x_start;
	assign train_load = br_ok && !abort && !x_start &&
		(state == ST_IDLE || (state == ST_TRAIN && !train_close));
	assign train_len = CNT_W'(train_fall - train_start);
	assign max_unroll = CNT_W'(BUF_DEPTH) / train_len;

	// first bundle takes its loop end from the table entry itself
	assign end_addr = x_start ? d_pc + SLOT_W'(ent_len[hit_idx]) - SLOT_W'(1) :
		disp_fall - SLOT_W'(1);
	assign end_off = end_addr - d_pc;
	assign rem_cur = x_start ? ent_max[hit_idx] : disp_rem;
	assign rem_next = x_end_hit ? rem_cur - CNT_W'(1) : rem_cur;

	assign x_valid = d_valid;
	assign x_dispatching = disp_now;
	assign x_end_hit = disp_now && d_valid && end_off < SLOT_W'(SLOTS);
	assign x_end_slot = end_off[SLOT_IDX_W-1:0];
	assign x_finish = x_end_hit && rem_next == '0;
	assign loop_state = state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			ent_valid <= '0;
			wr_ptr <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (x_start)
						state <= ST_DISPATCH;
					else if (train_load)
						state <= ST_TRAIN;
				end
				ST_TRAIN: begin
					if (abort) begin
						state <= ST_IDLE;
					end else if (x_start) begin
						state <= ST_DISPATCH;
					end else if (train_write) begin
						ent_valid[wr_ptr] <= 1'b1;
						wr_ptr <= wr_ptr + PTR_W'(1);
						state <= ST_IDLE;
					end
				end
				ST_DISPATCH: begin
					if (abort || x_finish)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (train_load) begin
			train_start <= d_bb_target;
			train_fall <= br_addr + SLOT_W'(1);
		end
		if (train_write) begin
			ent_start[wr_ptr] <= train_start;
			ent_fall[wr_ptr] <= train_fall;
			ent_len[wr_ptr] <= train_len;
			ent_max[wr_ptr] <= max_unroll;
		end
		if (x_start)
			disp_fall <= ent_fall[hit_idx];
		if (disp_now)
			disp_rem <= rem_next;
	end

endmodule

/* loop_table/lat_result.sv */
`timescale 1ns/1ps

module lat_result import isa_pkg::*, lat_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  x_valid,
	input  logic                  x_start,
	input  logic                  x_dispatching,
	input  logic                  x_end_hit,
	input  logic [SLOT_IDX_W-1:0] x_end_slot,
	input  logic                  x_finish,
	output logic [SLOTS-1:0]      inst_valid,
	output logic                  loop_start,
	output logic                  finish_unroll,
	output logic                  stall_fetch
);

	logic [SLOTS-1:0]    mask;
	logic [SLOT_IDX_W:0] mask_ones;
	logic [CNT_W-1:0]    cnt;
	logic [CNT_W-1:0]    cnt_base;
	logic [CNT_W:0]      cnt_sum;
	logic                cnt_full;

	// slots past the loop-closing branch are dropped
	always_comb begin
		if (!x_valid)
			mask = '0;
		else if (x_end_hit)
			mask = {SLOTS{1'b1}} >> (SLOT_IDX_W'(SLOTS - 1) - x_end_slot);
		else
			mask = '1;
	end

	always_comb begin
		mask_ones = '0;
		for (int i = 0; i < SLOTS; i++)
			mask_ones = mask_ones + (SLOT_IDX_W+1)'(mask[i]);
	end

	assign cnt_base = x_start ? '0 : cnt;
	assign cnt_sum = {1'b0, cnt_base} + (CNT_W+1)'(mask_ones);
	assign cnt_full = cnt_sum >= (CNT_W+1)'(BUF_DEPTH);

	always_ff @(posedge clk) begin
		if (rst) begin
			inst_valid <= '0;
			loop_start <= 1'b0;
			finish_unroll <= 1'b0;
			stall_fetch <= 1'b0;
			cnt <= '0;
		end else begin
			inst_valid <= mask;
			loop_start <= x_start;
			finish_unroll <= x_finish;
			if (!x_dispatching || x_finish) begin
				cnt <= '0;
				stall_fetch <= 1'b0;
			end else begin
				// saturate at the buffer depth
				cnt <= cnt_full ? CNT_W'(BUF_DEPTH) : cnt_sum[CNT_W-1:0];
				stall_fetch <= cnt_full;
			end
		end
	end

endmodule
